//--- pdp_consts.svh
/* PDP-11 bus constants
   address map, RAM depth, device slots and interrupt vectors and priorities */

`ifndef PDP_BUS_CONSTS_SVH
`define PDP_BUS_CONSTS_SVH

// word RAM, upper RAM-region addresses wrap onto these bits
`define RAM_WORDS 4096
`define RAM_AW 12

// top 8 KB of each 64 KB window
`define IOPAGE_MSB 3'b111

// read value where nothing answers
`define UNMAPPED_DATA 16'hffff

`define NUM_DEV 4

// slot 0 csr, 777500 in the 18-bit i/o page
`define DEV_BASE 16'o177500

`define DEV_VEC_BASE 8'o300
`define DEV_IPL_BASE 4

`endif

//--- bus_pkg.sv
/* CPU bus types
   address and data words and the region an access falls into */

`default_nettype none

package bus_pkg;

   // 22-bit physical byte address
   typedef logic [21:0] bus_addr_t;

   typedef logic [15:0] bus_word_t;

   // picked from address bits 21:13
   typedef enum logic [1:0]
   {
      region_ram,
      region_iopage,
      region_none
   } bus_region_t;

endpackage

`default_nettype wire

//--- dev_pkg.sv
/* I/O page device types
   register offsets, CSR bit positions and the interrupt request word */

`default_nettype none

package dev_pkg;

   // even word is csr, odd word is the data buffer
   typedef enum logic
   {
      reg_csr,
      reg_buf
   } dev_reg_t;

   localparam int csr_ie_bit = 6;
   localparam int csr_done_bit = 7;

   typedef struct packed
   {
      logic       pending;
      logic [7:0] ipl;
      logic [7:0] vector;
   } irq_req_t;

endpackage

`default_nettype wire

//--- dev_if.sv
/* device slot interface
   decoder strobes in, register data and interrupt request out, acknowledge back */

`timescale 1ns/1ps
`default_nettype none

interface dev_if;
   import bus_pkg::*;
   import dev_pkg::*;

   logic      sel;
   logic      rd;
   logic      wr;
   logic      byte_op;
   // odd byte address, only meaningful with byte_op
   logic      byte_hi;
   dev_reg_t  reg_sel;
   bus_word_t wdata;

   bus_word_t rdata;
   irq_req_t  irq;

   logic      int_ack;

   modport dec
   (
      output sel, rd, wr, byte_op, byte_hi, reg_sel, wdata
   );

   modport dev
   (
      input  rd, wr, byte_op, byte_hi, reg_sel, wdata, int_ack,
      output rdata, irq
   );

   modport col
   (
      input  sel, rdata, irq,
      output int_ack
   );

endinterface

`default_nettype wire

//--- bus_decode.sv
/* bus address decoder
   sorts each access into RAM, I/O page or unmapped and selects a device slot */

`timescale 1ns/1ps
`default_nettype none

`include "pdp_consts.svh"

module bus_decode
(
   input  bus_pkg::bus_addr_t   bus_addr,
   input  logic                 bus_rd,
   input  logic                 bus_wr,
   input  logic                 bus_byte_op,
   input  bus_pkg::bus_word_t   data_in,
   output bus_pkg::bus_region_t region,
   dev_if.dec                   slot [`NUM_DEV]
);
   import bus_pkg::*;
   import dev_pkg::*;

   logic [`NUM_DEV-1:0] sel_vec;

   // i/o page checked first since it sits in every window
   always_comb
   begin
      if (bus_addr[15:13] == `IOPAGE_MSB)
         region = region_iopage;
      else if (bus_addr[21:16] == 6'b0)
         region = region_ram;
      else
         region = region_none;
   end

   genvar i;
   generate
      for (i = 0; i < `NUM_DEV; i++)
      begin : g_slot
         localparam logic [15:0] csr_addr = `DEV_BASE + 4 * i;
         localparam logic [15:0] data_addr = csr_addr + 16'd2;

         logic csr_hit;
         logic data_hit;

         // word compare so byte accesses hit either half
         assign csr_hit = bus_addr[15:1] == csr_addr[15:1];
         assign data_hit = bus_addr[15:1] == data_addr[15:1];

         assign sel_vec[i] = (region == region_iopage) && (csr_hit || data_hit);

         assign slot[i].sel = sel_vec[i];
         assign slot[i].rd = bus_rd && sel_vec[i];
         assign slot[i].wr = bus_wr && sel_vec[i];
         assign slot[i].byte_op = bus_byte_op;
         assign slot[i].byte_hi = bus_addr[0];
         assign slot[i].reg_sel = data_hit ? reg_buf : reg_csr;
         assign slot[i].wdata = data_in;
      end
   endgenerate

endmodule

`default_nettype wire

//--- mem_arbiter.sv
/* memory arbiter and word RAM
   alternates the RAM between CPU and DMA and writes single bytes or whole words */

`timescale 1ns/1ps
`default_nettype none

`include "pdp_consts.svh"

module mem_arbiter
(
   input  logic               clk,
   input  logic               reset,
   input  bus_pkg::bus_addr_t bus_addr,
   input  bus_pkg::bus_word_t data_in,
   input  logic               bus_rd,
   input  logic               bus_wr,
   input  logic               bus_byte_op,
   input  logic               ram_sel,
   output bus_pkg::bus_word_t ram_rdata,
   output logic               bus_ack,
   input  logic               dma_req,
   input  bus_pkg::bus_addr_t dma_addr,
   input  bus_pkg::bus_word_t dma_data,
   input  logic               dma_wr,
   output logic               dma_ack
);
   import bus_pkg::*;

   logic               grant_cpu;
   logic               grant_dma;
   logic [`RAM_AW-1:0] ram_addr;
   logic [1:0]         lane_we;
   bus_word_t          ram_wdata;
   bus_word_t          ram [`RAM_WORDS];

   // dma gets one cycle and the cpu at least one after it
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         grant_cpu <= 1'b1;
         grant_dma <= 1'b0;
      end
      else if (dma_req && !grant_dma)
      begin
         grant_cpu <= 1'b0;
         grant_dma <= 1'b1;
      end
      else
      begin
         grant_cpu <= 1'b1;
         grant_dma <= 1'b0;
      end
   end

   assign bus_ack = grant_cpu;
   assign dma_ack = grant_dma;

   assign ram_addr = grant_cpu ? bus_addr[`RAM_AW:1] : dma_addr[`RAM_AW:1];

   // byte data arrives in the low lane and is copied up for odd addresses
   always_comb
   begin
      lane_we = 2'b00;
      ram_wdata = dma_data;
      if (grant_cpu)
      begin
         ram_wdata = bus_byte_op ? {data_in[7:0], data_in[7:0]} : data_in;
         if (bus_wr && ram_sel)
         begin
            if (!bus_byte_op)
               lane_we = 2'b11;
            else if (bus_addr[0])
               lane_we = 2'b10;
            else
               lane_we = 2'b01;
         end
      end
      else if (grant_dma && dma_wr)
         lane_we = 2'b11;
   end

   always_ff @(posedge clk)
   begin
      if (lane_we[0])
         ram[ram_addr][7:0] <= ram_wdata[7:0];
      if (lane_we[1])
         ram[ram_addr][15:8] <= ram_wdata[15:8];
   end

   assign ram_rdata = ram[ram_addr];

   // cpu side must not read and write in one taken cycle
   a_cpu_strobe: assert property (@(posedge clk) disable iff (reset)
      (grant_cpu && ram_sel) |-> !(bus_rd && bus_wr))
      else $error("mem_arbiter: bus_rd and bus_wr high together");

endmodule

`default_nettype wire

//--- io_device.sv
/* I/O page register device
   CSR with interrupt enable and done, a data buffer, and a vectored interrupt request */

`timescale 1ns/1ps
`default_nettype none

module io_device
#(
   parameter logic [7:0] dev_vector = 8'o300,
   parameter logic [7:0] dev_ipl = 8'd4
)
(
   input logic clk,
   input logic reset,
   dev_if.dev  bus
);
   import bus_pkg::*;
   import dev_pkg::*;

   logic      csr_ie;
   logic      csr_done;
   bus_word_t buffer;
   bus_word_t csr_word;
   logic      low_lane;

   // ie and done both live in the low byte
   assign low_lane = !bus.byte_op || !bus.byte_hi;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         csr_ie <= 1'b0;
         csr_done <= 1'b0;
         buffer <= '0;
      end
      else
      begin
         if (bus.int_ack)
            csr_done <= 1'b0;

         if (bus.wr && bus.reg_sel == reg_buf)
         begin
            if (!bus.byte_op)
               buffer <= bus.wdata;
            else if (bus.byte_hi)
               buffer[15:8] <= bus.wdata[7:0];
            else
               buffer[7:0] <= bus.wdata[7:0];
            csr_done <= 1'b1;
         end

         if (bus.wr && bus.reg_sel == reg_csr && low_lane)
         begin
            csr_ie <= bus.wdata[csr_ie_bit];
            if (!bus.wdata[csr_done_bit])
               csr_done <= 1'b0;
         end
      end
   end

   always_comb
   begin
      csr_word = '0;
      csr_word[csr_ie_bit] = csr_ie;
      csr_word[csr_done_bit] = csr_done;
   end

   // zero when not read, the collector ORs all slots
   assign bus.rdata = !bus.rd ? '0 : (bus.reg_sel == reg_csr) ? csr_word : buffer;

   assign bus.irq = '{pending: csr_done && csr_ie, ipl: dev_ipl, vector: dev_vector};

   a_ack_pending: assert property (@(posedge clk) disable iff (reset)
      bus.int_ack |-> (csr_done && csr_ie))
      else $error("io_device: int_ack without a pending request");

endmodule

`default_nettype wire

//--- io_collect.sv
/* I/O collector
   read data mux, interrupt priority search with acknowledge, and bus error */

`timescale 1ns/1ps
`default_nettype none

`include "pdp_consts.svh"

module io_collect
(
   input  logic                 clk,
   input  logic                 reset,
   dev_if.col                   slot [`NUM_DEV],
   input  bus_pkg::bus_region_t region,
   input  logic                 bus_rd,
   input  logic                 bus_wr,
   input  bus_pkg::bus_word_t   ram_rdata,
   output bus_pkg::bus_word_t   data_out,
   output logic                 bus_error,
   output logic                 interrupt,
   output logic [7:0]           interrupt_ipl,
   output logic [7:0]           vector,
   input  logic [7:0]           ack_ipl
);
   import bus_pkg::*;
   import dev_pkg::*;

   localparam int idx_w = (`NUM_DEV > 1) ? $clog2(`NUM_DEV) : 1;

   irq_req_t            irq_vec [`NUM_DEV];
   bus_word_t           rdata_vec [`NUM_DEV];
   logic [`NUM_DEV-1:0] sel_vec;
   bus_word_t           dev_rdata;
   logic [idx_w-1:0]    win_idx;
   logic                ack_match;
   logic                ack_hold;
   logic                ack_fire;

   genvar i;
   generate
      for (i = 0; i < `NUM_DEV; i++)
      begin : g_slot
         assign irq_vec[i] = slot[i].irq;
         assign rdata_vec[i] = slot[i].rdata;
         assign sel_vec[i] = slot[i].sel;
         assign slot[i].int_ack = ack_fire && (win_idx == i);
      end
   endgenerate

   always_comb
   begin
      dev_rdata = '0;
      for (int k = 0; k < `NUM_DEV; k++)
         dev_rdata = dev_rdata | rdata_vec[k];
   end

   always_comb
   begin
      case (region)
         region_ram:    data_out = ram_rdata;
         region_iopage: data_out = dev_rdata;
         default:       data_out = `UNMAPPED_DATA;
      endcase
   end

   // no slot answered an i/o page cycle
   assign bus_error = (region == region_iopage) && (bus_rd || bus_wr) && !(|sel_vec);

   // strict compare keeps the lowest slot on equal ipl
   always_comb
   begin
      interrupt = 1'b0;
      interrupt_ipl = '0;
      vector = '0;
      win_idx = '0;
      for (int k = 0; k < `NUM_DEV; k++)
      begin
         if (irq_vec[k].pending && (!interrupt || irq_vec[k].ipl > interrupt_ipl))
         begin
            interrupt = 1'b1;
            interrupt_ipl = irq_vec[k].ipl;
            vector = irq_vec[k].vector;
            win_idx = idx_w'(k);
         end
      end
   end

   assign ack_match = interrupt && (ack_ipl != 8'd0) && (ack_ipl == interrupt_ipl);

   // quiet for one cycle after an ack so a held ack_ipl cannot fire twice
   assign ack_fire = ack_match && !ack_hold;

   always_ff @(posedge clk)
   begin
      if (reset)
         ack_hold <= 1'b0;
      else
         ack_hold <= ack_fire;
   end

endmodule

`default_nettype wire

//--- pdp_bus_top.sv
/* PDP-11 style memory and I/O page bus
   CPU and DMA ports, shared word RAM, and a row of interrupting register devices */

`timescale 1ns/1ps
`default_nettype none

`include "pdp_consts.svh"

module pdp_bus_top
(
   input  logic               clk,
   input  logic               reset,
   input  bus_pkg::bus_addr_t bus_addr,
   input  bus_pkg::bus_word_t data_in,
   output bus_pkg::bus_word_t data_out,
   input  logic               bus_rd,
   input  logic               bus_wr,
   input  logic               bus_byte_op,
   output logic               bus_ack,
   output logic               bus_error,
   output logic               interrupt,
   output logic [7:0]         interrupt_ipl,
   input  logic [7:0]         ack_ipl,
   output logic [7:0]         vector,
   input  logic               dma_req,
   input  bus_pkg::bus_addr_t dma_addr,
   input  bus_pkg::bus_word_t dma_data,
   input  logic               dma_wr,
   output logic               dma_ack,
   output bus_pkg::bus_word_t dma_rdata
);
   import bus_pkg::*;

   bus_region_t region;
   bus_word_t   ram_rdata;
   logic        ram_sel;

   dev_if slot [`NUM_DEV] ();

   assign ram_sel = region == region_ram;
   assign dma_rdata = ram_rdata;

   bus_decode u_decode
   (
      .bus_addr    (bus_addr),
      .bus_rd      (bus_rd),
      .bus_wr      (bus_wr),
      .bus_byte_op (bus_byte_op),
      .data_in     (data_in),
      .region      (region),
      .slot        (slot)
   );

   mem_arbiter u_arbiter
   (
      .clk         (clk),
      .reset       (reset),
      .bus_addr    (bus_addr),
      .data_in     (data_in),
      .bus_rd      (bus_rd),
      .bus_wr      (bus_wr),
      .bus_byte_op (bus_byte_op),
      .ram_sel     (ram_sel),
      .ram_rdata   (ram_rdata),
      .bus_ack     (bus_ack),
      .dma_req     (dma_req),
      .dma_addr    (dma_addr),
      .dma_data    (dma_data),
      .dma_wr      (dma_wr),
      .dma_ack     (dma_ack)
   );

   genvar i;
   generate
      for (i = 0; i < `NUM_DEV; i++)
      begin : g_dev
         // priority climbs by slot, capped at 7
         localparam int ipl_raw = `DEV_IPL_BASE + i;

         io_device
         #(
            .dev_vector (8'(`DEV_VEC_BASE + 4 * i)),
            .dev_ipl    (8'((ipl_raw > 7) ? 7 : ipl_raw))
         )
         u_dev
         (
            .clk   (clk),
            .reset (reset),
            .bus   (slot[i])
         );
      end
   endgenerate

   io_collect u_collect
   (
      .clk           (clk),
      .reset         (reset),
      .slot          (slot),
      .region        (region),
      .bus_rd        (bus_rd),
      .bus_wr        (bus_wr),
      .ram_rdata     (ram_rdata),
      .data_out      (data_out),
      .bus_error     (bus_error),
      .interrupt     (interrupt),
      .interrupt_ipl (interrupt_ipl),
      .vector        (vector),
      .ack_ipl       (ack_ipl)
   );

endmodule

`default_nettype wire

//--- tb_pdp_bus.sv
/* PDP-11 bus testbench
   drives the CPU, DMA and interrupt ports and checks them against RAM and device models */

`timescale 1ns/1ps
`default_nettype none

`include "pdp_consts.svh"

module tb_pdp_bus;

   localparam logic [1:0] rgn_ram = 2'd0;
   localparam logic [1:0] rgn_io = 2'd1;
   localparam logic [1:0] rgn_none = 2'd2;
   localparam int timeout_cycles = 50;
   localparam int num_ram_ops = 48;
   localparam int num_dma_ops = 8;

   logic        clk = 1'b0;
   logic        reset;
   logic [21:0] bus_addr;
   logic [15:0] data_in;
   logic [15:0] data_out;
   logic        bus_rd;
   logic        bus_wr;
   logic        bus_byte_op;
   logic        bus_ack;
   logic        bus_error;
   logic        interrupt;
   logic [7:0]  interrupt_ipl;
   logic [7:0]  ack_ipl;
   logic [7:0]  vector;
   logic        dma_req;
   logic [21:0] dma_addr;
   logic [15:0] dma_data;
   logic        dma_wr;
   logic        dma_ack;
   logic [15:0] dma_rdata;

   // known holds a mask of the shadow RAM bits written so far
   logic [15:0] shadow [`RAM_WORDS];
   logic [15:0] known [`RAM_WORDS];
   logic [15:0] dev_buf [`NUM_DEV];
   logic        dev_ie [`NUM_DEV];
   logic        dev_done [`NUM_DEV];
   logic        ack_hold;
   logic        ack_fire;

   logic [1:0]  exp_region;
   logic [15:0] dev_off;
   logic        exp_hit;
   int          exp_slot;
   logic        exp_is_buf;
   logic [15:0] exp_dev_data;
   logic        exp_bus_error;
   logic [15:0] exp_ram;
   logic [15:0] exp_mask;
   logic [15:0] exp_dma;
   logic [15:0] exp_dma_mask;
   logic        exp_int;
   logic [7:0]  exp_ipl;
   logic [7:0]  exp_vec;
   int          exp_win;

   integer      seed;
   logic [31:0] r;
   logic [21:0] ram_list [num_ram_ops];
   logic [21:0] dma_list [num_dma_ops];
   int          n;
   int          total;
   int          ram_errs;
   int          dev_errs;
   int          irq_errs;
   int          bus_errs;
   int          arb_errs;
   int          timeouts;

   pdp_bus_top pdp_bus_top_inst
   (
      .clk           (clk),
      .reset         (reset),
      .bus_addr      (bus_addr),
      .data_in       (data_in),
      .data_out      (data_out),
      .bus_rd        (bus_rd),
      .bus_wr        (bus_wr),
      .bus_byte_op   (bus_byte_op),
      .bus_ack       (bus_ack),
      .bus_error     (bus_error),
      .interrupt     (interrupt),
      .interrupt_ipl (interrupt_ipl),
      .ack_ipl       (ack_ipl),
      .vector        (vector),
      .dma_req       (dma_req),
      .dma_addr      (dma_addr),
      .dma_data      (dma_data),
      .dma_wr        (dma_wr),
      .dma_ack       (dma_ack),
      .dma_rdata     (dma_rdata)
   );

   always #10 clk = ~clk;

   // top 8 KB of every 64 KB window is the i/o page
   function automatic logic [1:0] region_of(input logic [21:0] a);
      if (a[15:13] == 3'b111)
         return rgn_io;
      else if (a[21:16] == 6'd0)
         return rgn_ram;
      return rgn_none;
   endfunction

   function automatic logic [7:0] ipl_of(input int k);
      return (`DEV_IPL_BASE + k > 7) ? 8'd7 : 8'(`DEV_IPL_BASE + k);
   endfunction

   function automatic logic [21:0] ram_addr_of(input logic [31:0] rnd);
      logic [15:0] a;
      a = rnd[15:0];
      if (a[15:13] == 3'b111)
         a[15] = 1'b0;
      return {6'd0, a};
   endfunction

   function automatic logic [21:0] dev_addr(input int k, input int ofs);
      return {6'd0, 16'(`DEV_BASE + 4 * k + ofs)};
   endfunction

   assign dev_off = bus_addr[15:0] - `DEV_BASE;
   assign exp_ram = shadow[bus_addr[`RAM_AW:1]];
   assign exp_mask = known[bus_addr[`RAM_AW:1]];
   assign exp_dma = shadow[dma_addr[`RAM_AW:1]];
   assign exp_dma_mask = known[dma_addr[`RAM_AW:1]];
   assign ack_fire = exp_int && (ack_ipl != 8'd0) && (ack_ipl == exp_ipl) && !ack_hold;

   always_comb
   begin
      exp_region = region_of(bus_addr);
      exp_hit = (exp_region == rgn_io) && (dev_off < 16'(4 * `NUM_DEV));
      exp_slot = int'(dev_off[15:2]);
      exp_is_buf = dev_off[1];
      exp_dev_data = 16'h0000;
      if (exp_hit)
         exp_dev_data = exp_is_buf ? dev_buf[exp_slot] :
                        {8'h00, dev_done[exp_slot], dev_ie[exp_slot], 6'h00};
      exp_bus_error = (exp_region == rgn_io) && (bus_rd || bus_wr) && !exp_hit;
   end

   // highest ipl wins and the lowest slot breaks a tie
   always_comb
   begin
      exp_int = 1'b0;
      exp_ipl = 8'h00;
      exp_vec = 8'h00;
      exp_win = 0;
      for (int k = 0; k < `NUM_DEV; k++)
      begin
         if (dev_done[k] && dev_ie[k] && (!exp_int || ipl_of(k) > exp_ipl))
         begin
            exp_int = 1'b1;
            exp_ipl = ipl_of(k);
            exp_vec = 8'(`DEV_VEC_BASE + 4 * k);
            exp_win = k;
         end
      end
   end

   always @(posedge clk)
   begin
      if (reset)
      begin
         for (int k = 0; k < `NUM_DEV; k++)
         begin
            dev_buf[k] <= 16'h0000;
            dev_ie[k] <= 1'b0;
            dev_done[k] <= 1'b0;
         end
         ack_hold <= 1'b0;
      end
      else
      begin
         ack_hold <= ack_fire;
         if (ack_fire)
            dev_done[exp_win] <= 1'b0;
         if (bus_ack && bus_wr && exp_region == rgn_ram)
         begin
            if (!bus_byte_op)
            begin
               shadow[bus_addr[`RAM_AW:1]] <= data_in;
               known[bus_addr[`RAM_AW:1]] <= 16'hffff;
            end
            else if (bus_addr[0])
            begin
               shadow[bus_addr[`RAM_AW:1]][15:8] <= data_in[7:0];
               known[bus_addr[`RAM_AW:1]][15:8] <= 8'hff;
            end
            else
            begin
               shadow[bus_addr[`RAM_AW:1]][7:0] <= data_in[7:0];
               known[bus_addr[`RAM_AW:1]][7:0] <= 8'hff;
            end
         end
         if (bus_ack && bus_wr && exp_hit)
         begin
            if (exp_is_buf)
            begin
               if (!bus_byte_op)
                  dev_buf[exp_slot] <= data_in;
               else if (bus_addr[0])
                  dev_buf[exp_slot][15:8] <= data_in[7:0];
               else
                  dev_buf[exp_slot][7:0] <= data_in[7:0];
               dev_done[exp_slot] <= 1'b1;
            end
            else if (!bus_byte_op || !bus_addr[0])
            begin
               dev_ie[exp_slot] <= data_in[6];
               if (!data_in[7])
                  dev_done[exp_slot] <= 1'b0;
            end
         end
         if (dma_ack && dma_wr)
         begin
            shadow[dma_addr[`RAM_AW:1]] <= dma_data;
            known[dma_addr[`RAM_AW:1]] <= 16'hffff;
         end
      end
   end

   a_reset_state: assert property (@(posedge clk) $fell(reset) |->
      (bus_ack && !dma_ack && !interrupt))
      else
      begin
         arb_errs++;
         $display("FAIL bus_ack/dma_ack/interrupt expected 1/0/0 actual %h/%h/%h",
                  $sampled(bus_ack), $sampled(dma_ack), $sampled(interrupt));
      end

   a_ram_read: assert property (@(posedge clk) disable iff (reset)
      (bus_rd && bus_ack && exp_region == rgn_ram) |->
      ((data_out ^ exp_ram) & exp_mask) == 16'h0000)
      else
      begin
         ram_errs++;
         $display("FAIL data_out expected %h actual %h", $sampled(exp_ram), $sampled(data_out));
      end

   a_dma_read: assert property (@(posedge clk) disable iff (reset)
      dma_ack |-> ((dma_rdata ^ exp_dma) & exp_dma_mask) == 16'h0000)
      else
      begin
         ram_errs++;
         $display("FAIL dma_rdata expected %h actual %h", $sampled(exp_dma), $sampled(dma_rdata));
      end

   a_unmapped: assert property (@(posedge clk) disable iff (reset)
      (bus_rd && exp_region == rgn_none) |-> data_out == 16'hffff)
      else
      begin
         bus_errs++;
         $display("FAIL data_out expected ffff actual %h", $sampled(data_out));
      end

   a_bus_error: assert property (@(posedge clk) disable iff (reset)
      bus_error == exp_bus_error)
      else
      begin
         bus_errs++;
         $display("FAIL bus_error expected %h actual %h",
                  $sampled(exp_bus_error), $sampled(bus_error));
      end

   a_dev_read: assert property (@(posedge clk) disable iff (reset)
      (bus_rd && exp_hit) |-> data_out == exp_dev_data)
      else
      begin
         dev_errs++;
         $display("FAIL data_out expected %h actual %h",
                  $sampled(exp_dev_data), $sampled(data_out));
      end

   a_one_grant: assert property (@(posedge clk) disable iff (reset) bus_ack != dma_ack)
      else
      begin
         arb_errs++;
         $display("bus_ack and dma_ack are both high or both low");
      end

   a_dma_grant: assert property (@(posedge clk) disable iff (reset)
      (dma_req && !dma_ack) |=> dma_ack)
      else
      begin
         arb_errs++;
         $display("dma_ack did not follow a waiting dma_req");
      end

   a_dma_single: assert property (@(posedge clk) disable iff (reset) dma_ack |=> !dma_ack)
      else
      begin
         arb_errs++;
         $display("dma_ack held for more than one cycle");
      end

   a_int_level: assert property (@(posedge clk) disable iff (reset) interrupt == exp_int)
      else
      begin
         irq_errs++;
         $display("FAIL interrupt expected %h actual %h", $sampled(exp_int), $sampled(interrupt));
      end

   a_int_ipl: assert property (@(posedge clk) disable iff (reset)
      exp_int |-> (interrupt_ipl == exp_ipl && vector == exp_vec))
      else
      begin
         irq_errs++;
         $display("FAIL interrupt_ipl/vector expected %h/%h actual %h/%h", $sampled(exp_ipl),
                  $sampled(exp_vec), $sampled(interrupt_ipl), $sampled(vector));
      end

   // holds the strobes until an edge with bus_ack high takes the cycle
   task automatic cpu_access(input logic [21:0] addr, input logic [15:0] data,
                             input logic write, input logic byte_op);
      int cnt;
      bus_addr <= addr;
      data_in <= data;
      bus_rd <= !write;
      bus_wr <= write;
      bus_byte_op <= byte_op;
      cnt = 0;
      do
      begin
         @(posedge clk);
         cnt++;
      end
      while (!bus_ack && cnt < timeout_cycles);
      if (!bus_ack)
      begin
         timeouts++;
         $display("timeout: CPU cycle at %h never saw bus_ack", addr);
      end
   endtask

   task automatic dma_write(input logic [21:0] addr, input logic [15:0] data);
      int cnt;
      dma_req <= 1'b1;
      dma_wr <= 1'b1;
      dma_addr <= addr;
      dma_data <= data;
      cnt = 0;
      do
      begin
         @(posedge clk);
         cnt++;
      end
      while (!dma_ack && cnt < timeout_cycles);
      if (!dma_ack)
      begin
         timeouts++;
         $display("timeout: DMA write at %h never saw dma_ack", addr);
      end
   endtask

   task automatic idle_cycle();
      bus_rd <= 1'b0;
      bus_wr <= 1'b0;
      @(posedge clk);
   endtask

   initial
   begin
      seed = 96;
      ram_errs = 0;
      dev_errs = 0;
      irq_errs = 0;
      bus_errs = 0;
      arb_errs = 0;
      timeouts = 0;
      for (int i = 0; i < `RAM_WORDS; i++)
         known[i] = 16'h0000;
      reset = 1'b1;
      bus_addr = 22'd0;
      data_in = 16'h0000;
      bus_rd = 1'b0;
      bus_wr = 1'b0;
      bus_byte_op = 1'b0;
      ack_ipl = 8'h00;
      dma_req = 1'b0;
      dma_addr = 22'd0;
      dma_data = 16'h0000;
      dma_wr = 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);

      // random word and byte writes followed by reads
      for (int i = 0; i < num_ram_ops; i++)
      begin
         r = $random(seed);
         ram_list[i] = ram_addr_of(r);
         cpu_access(ram_list[i], r[31:16], 1'b1, r[20]);
      end
      for (int i = 0; i < num_ram_ops; i++)
         cpu_access(ram_list[i], 16'h0000, 1'b0, 1'b0);
      // wrap above the RAM depth
      cpu_access(22'h000010, 16'ha5c3, 1'b1, 1'b0);
      cpu_access(22'h002010, 16'h0000, 1'b0, 1'b0);
      cpu_access(22'h00c010, 16'h0000, 1'b0, 1'b0);

      // unmapped windows and undecoded i/o page addresses
      for (int i = 1; i < 5; i++)
      begin
         r = $random(seed);
         cpu_access({6'(i), 3'b000, r[12:0]}, 16'h0000, 1'b0, 1'b0);
      end
      cpu_access(22'h00e000, 16'h0000, 1'b0, 1'b0);
      cpu_access(22'h00ff80, 16'h1234, 1'b1, 1'b0);
      cpu_access(22'h03ff3e, 16'h0000, 1'b0, 1'b0);
      cpu_access(22'h01ff42, 16'h0000, 1'b0, 1'b0);
      idle_cycle();

      // DMA burst against concurrent CPU reads
      // DMA lands on words the CPU wrote before
      for (int i = 0; i < num_dma_ops; i++)
         dma_list[i] = ram_list[2 * i + 1];
      fork
         begin
            for (int i = 0; i < num_dma_ops; i++)
               dma_write(dma_list[i], 16'(16'h5a00 + i));
            dma_req <= 1'b0;
            dma_wr <= 1'b0;
         end
         begin
            for (int i = 0; i < 2 * num_dma_ops; i++)
               cpu_access(ram_list[i], 16'h0000, 1'b0, 1'b0);
         end
      join
      for (int i = 0; i < num_dma_ops; i++)
         cpu_access(dma_list[i], 16'h0000, 1'b0, 1'b0);

      // buffer and csr per slot
      for (int k = 0; k < `NUM_DEV; k++)
      begin
         r = $random(seed);
         cpu_access(dev_addr(k, 2), r[15:0], 1'b1, 1'b0);
         cpu_access(dev_addr(k, 2), 16'h0000, 1'b0, 1'b0);
         cpu_access(dev_addr(k, 0), 16'h0000, 1'b0, 1'b0);
         cpu_access(dev_addr(k, 3), r[31:16], 1'b1, 1'b1);
         cpu_access(dev_addr(k, 1), 16'h00ff, 1'b1, 1'b1);
         cpu_access(dev_addr(k, 2), 16'h0000, 1'b0, 1'b0);
         cpu_access(dev_addr(k, 0), 16'h0000, 1'b1, 1'b0);
         cpu_access(dev_addr(k, 0), 16'h0000, 1'b0, 1'b0);
      end

      // interrupts from slots 0, 1 and 3
      cpu_access(dev_addr(0, 0), 16'h0040, 1'b1, 1'b0);
      cpu_access(dev_addr(1, 0), 16'h0040, 1'b1, 1'b0);
      cpu_access(dev_addr(3, 0), 16'h0040, 1'b1, 1'b0);
      cpu_access(dev_addr(0, 2), 16'h1111, 1'b1, 1'b0);
      cpu_access(dev_addr(1, 2), 16'h2222, 1'b1, 1'b0);
      cpu_access(dev_addr(3, 2), 16'h4444, 1'b1, 1'b0);
      idle_cycle();
      // a wrong level must not acknowledge
      ack_ipl <= 8'd1;
      @(posedge clk);
      ack_ipl <= 8'h00;
      @(posedge clk);
      n = 0;
      while (interrupt && n < 2 * `NUM_DEV)
      begin
         ack_ipl <= interrupt_ipl;
         @(posedge clk);
         ack_ipl <= 8'h00;
         @(posedge clk);
         n++;
      end
      if (interrupt)
      begin
         timeouts++;
         $display("timeout: interrupt still pending after servicing every slot");
      end
      idle_cycle();
      idle_cycle();

      total = ram_errs + dev_errs + irq_errs + bus_errs + arb_errs + timeouts;
      $display("errors: ram %0d, device %0d, interrupt %0d, bus %0d, arbiter %0d, timeout %0d",
               ram_errs, dev_errs, irq_errs, bus_errs, arb_errs, timeouts);
      if (total == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
bus_pkg.sv
dev_pkg.sv
dev_if.sv
bus_decode.sv
mem_arbiter.sv
io_device.sv
io_collect.sv
pdp_bus_top.sv
tb_pdp_bus.sv
